//--- eeprom_macros.svh
`ifndef EEPROM_MACROS_SVH
`define EEPROM_MACROS_SVH

// CLK cycles per quarter of an SCL period, 2 or more
`define EE_QUARTER 5

`define EE_DEV_CODE 4'b1010 // 24Cxx device type

`define EE_ADDR_W 11
`define EE_BLOCK_W 3 // address bits carried in the control byte

`endif

//--- eeprom_bus_pkg.sv
package eeprom_bus_pkg;

    typedef logic [7:0] bus_byte_t;

    typedef enum logic [2:0]
    {
        BUS_START,
        BUS_RESTART,
        BUS_STOP,
        BUS_WRITE,
        BUS_READ
    } bus_op_e;

    typedef struct packed
    {
        bus_op_e   op;
        bus_byte_t data; // byte to send for BUS_WRITE
        logic      nack; // bit driven after BUS_READ
    } bus_cmd_t;

    typedef struct packed
    {
        bus_byte_t data; // received byte
        logic      nack; // sampled acknowledge, 1 = not acked
    } bus_done_t;

endpackage

//--- eeprom_host_pkg.sv
`include "eeprom_macros.svh"

package eeprom_host_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [7:0] ee_data_t;

    typedef struct packed
    {
        logic     rd;   // 1 = random read
        ee_addr_t addr;
        ee_data_t data; // write only
    } ee_req_t;

    typedef struct packed
    {
        logic     rd;
        ee_data_t data; // zero for writes
        logic     nack; // slave failed to acknowledge
    } ee_rsp_t;

endpackage

//--- eeprom_req_decode.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module eeprom_req_decode
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      req_valid,
    input  eeprom_host_pkg::ee_req_t  req,
    input  logic                      busy,
    output logic                      txn_start,
    output logic                      is_read,
    output eeprom_bus_pkg::bus_byte_t ctrl_wr_byte,
    output eeprom_bus_pkg::bus_byte_t ctrl_rd_byte,
    output eeprom_bus_pkg::bus_byte_t addr_byte,
    output eeprom_bus_pkg::bus_byte_t data_byte
);
    eeprom_host_pkg::ee_req_t req_q;
    logic                     accept;

    assign accept = req_valid && !busy; // strobes while busy are dropped

    always_ff @(posedge CLK)
    begin
        if (RESET)
            txn_start <= 1'b0;
        else
            txn_start <= accept;
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            req_q <= req;
    end

    // block select rides in the control byte
    assign is_read      = req_q.rd;
    assign ctrl_wr_byte = {`EE_DEV_CODE, req_q.addr[`EE_ADDR_W-1 -: `EE_BLOCK_W], 1'b0};
    assign ctrl_rd_byte = {`EE_DEV_CODE, req_q.addr[`EE_ADDR_W-1 -: `EE_BLOCK_W], 1'b1};
    assign addr_byte    = req_q.addr[`EE_ADDR_W-`EE_BLOCK_W-1:0];
    assign data_byte    = req_q.data;

endmodule

//--- eeprom_seq_ctrl.sv
`timescale 1ns/1ps

module eeprom_seq_ctrl
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      txn_start,
    input  logic                      is_read,
    input  eeprom_bus_pkg::bus_byte_t ctrl_wr_byte,
    input  eeprom_bus_pkg::bus_byte_t ctrl_rd_byte,
    input  eeprom_bus_pkg::bus_byte_t addr_byte,
    input  eeprom_bus_pkg::bus_byte_t data_byte,
    input  logic                      done_valid,
    output logic                      cmd_valid,
    output eeprom_bus_pkg::bus_cmd_t  cmd,
    output logic                      clear,
    output logic                      finish,
    output logic                      busy
);
    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_CTRL,
        S_ADDR,
        S_DATA,
        S_RESTART,
        S_RD_CTRL,
        S_RD_BYTE,
        S_STOP
    } seq_state_e;

    seq_state_e state;
    seq_state_e next_state;

    // a nack does not shorten the sequence, stop always goes out
    always_comb
    begin
        case (state)
            S_START:   next_state = S_CTRL;
            S_CTRL:    next_state = S_ADDR;
            S_ADDR:    next_state = is_read ? S_RESTART : S_DATA;
            S_DATA:    next_state = S_STOP;
            S_RESTART: next_state = S_RD_CTRL;
            S_RD_CTRL: next_state = S_RD_BYTE;
            S_RD_BYTE: next_state = S_STOP;
            default:   next_state = S_IDLE;
        endcase
    end

    always_comb
    begin
        cmd.op   = eeprom_bus_pkg::BUS_WRITE;
        cmd.data = '0;
        cmd.nack = 1'b0;
        case (state)
            S_START:   cmd.op = eeprom_bus_pkg::BUS_START;
            S_CTRL:    cmd.data = ctrl_wr_byte;
            S_ADDR:    cmd.data = addr_byte;
            S_DATA:    cmd.data = data_byte;
            S_RESTART: cmd.op = eeprom_bus_pkg::BUS_RESTART;
            S_RD_CTRL: cmd.data = ctrl_rd_byte;
            S_RD_BYTE:
            begin
                cmd.op   = eeprom_bus_pkg::BUS_READ;
                cmd.nack = 1'b1; // single byte, master nacks
            end
            default:   cmd.op = eeprom_bus_pkg::BUS_STOP;
        endcase
    end

    assign finish = (state == S_STOP) && done_valid;
    assign busy   = (state != S_IDLE) || txn_start;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            cmd_valid <= 1'b0;
            clear     <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            clear     <= 1'b0;
            if (state == S_IDLE)
            begin
                if (txn_start)
                begin
                    state     <= S_START;
                    cmd_valid <= 1'b1;
                    clear     <= 1'b1;
                end
            end
            else if (done_valid)
            begin
                state     <= next_state;
                cmd_valid <= (next_state != S_IDLE);
            end
        end
    end

    cmd_single_cycle: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |=> !cmd_valid);

endmodule

//--- i2c_bit_engine.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module i2c_bit_engine
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      cmd_valid,
    input  eeprom_bus_pkg::bus_cmd_t  cmd,
    output logic                      done_valid,
    output eeprom_bus_pkg::bus_done_t done,
    output logic                      scl,
    output logic                      sda_oe,
    input  logic                      sda_in
);
    localparam int QW = $clog2(`EE_QUARTER);

    typedef enum logic [2:0]
    {
        E_IDLE,
        E_START,
        E_RESTART,
        E_STOP,
        E_WRITE,
        E_READ
    } eng_state_e;

    eng_state_e                state;
    eng_state_e                op_state;
    logic [QW-1:0]             qcnt;
    logic [1:0]                phase; // quarter within the slot
    logic [3:0]                bitn;  // 8 is the ack slot
    eeprom_bus_pkg::bus_byte_t shreg;
    logic                      ack_bit;
    logic                      nack_q;
    logic                      q_last;
    logic                      slot_last;
    logic                      cmd_last;
    logic                      bit_op;
    logic                      sample;
    logic                      scl_c;
    logic                      sda_c;
    logic                      bit_slot;

    assign q_last    = (qcnt == QW'(`EE_QUARTER - 1));
    assign slot_last = q_last && (phase == 2'd3);
    assign bit_op    = (state == E_WRITE) || (state == E_READ);
    assign cmd_last  = slot_last && (!bit_op || bitn == 4'd8);
    assign sample    = bit_op && (phase == 2'd1) && (qcnt == '0); // scl rising

    always_comb
    begin
        case (cmd.op)
            eeprom_bus_pkg::BUS_START:   op_state = E_START;
            eeprom_bus_pkg::BUS_RESTART: op_state = E_RESTART;
            eeprom_bus_pkg::BUS_STOP:    op_state = E_STOP;
            eeprom_bus_pkg::BUS_WRITE:   op_state = E_WRITE;
            default:                     op_state = E_READ;
        endcase
    end

    // scl high in the middle two quarters of a bit slot
    always_comb
    begin
        scl_c = (phase == 2'd1) || (phase == 2'd2);
        sda_c = 1'b0;
        case (state)
            E_START:
            begin
                scl_c = (phase != 2'd3);
                sda_c = (phase != 2'd0); // sda falls with scl high
            end
            E_RESTART: sda_c = phase[1];
            E_STOP:
            begin
                scl_c = (phase != 2'd0);
                sda_c = !phase[1]; // release with scl high
            end
            E_WRITE:   sda_c = (bitn != 4'd8) && !shreg[7];
            E_READ:    sda_c = (bitn == 4'd8) && !ack_bit;
            default:   scl_c = 1'b1;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= E_IDLE;
            qcnt       <= '0;
            phase      <= '0;
            bitn       <= '0;
            done_valid <= 1'b0;
            scl        <= 1'b1;
            sda_oe     <= 1'b0;
            bit_slot   <= 1'b0;
        end
        else
        begin
            done_valid <= 1'b0;
            if (state == E_IDLE)
            begin
                if (cmd_valid)
                begin
                    state <= op_state;
                    qcnt  <= '0;
                    phase <= '0;
                    bitn  <= '0;
                end
            end
            else
            begin
                scl      <= scl_c; // pins hold their level between commands
                sda_oe   <= sda_c;
                bit_slot <= bit_op;
                qcnt     <= q_last ? '0 : qcnt + 1'b1;
                if (q_last)
                    phase <= phase + 1'b1;
                if (slot_last)
                    bitn <= bitn + 1'b1;
                if (cmd_last)
                begin
                    state      <= E_IDLE;
                    done_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == E_IDLE && cmd_valid)
        begin
            shreg   <= cmd.data;
            ack_bit <= cmd.nack;
            nack_q  <= 1'b0;
        end
        else if (sample)
        begin
            if (bitn == 4'd8)
                nack_q <= sda_in;
            else if (state == E_READ)
                shreg <= {shreg[6:0], sda_in};
        end
        else if (slot_last && state == E_WRITE)
            shreg <= {shreg[6:0], 1'b0}; // msb first
    end

    assign done.data = shreg;
    assign done.nack = nack_q;

    cmd_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> state == E_IDLE);

    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && bit_slot && $past(bit_slot)) |-> $stable(sda_oe));

endmodule

//--- eeprom_result.sv
`timescale 1ns/1ps

module eeprom_result
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      clear,
    input  logic                      is_read,
    input  logic                      done_valid,
    input  eeprom_bus_pkg::bus_done_t done,
    input  logic                      finish,
    output logic                      rsp_valid,
    output eeprom_host_pkg::ee_rsp_t  rsp
);
    logic [2:0]                 cnt; // completions so far
    logic                       nack_q;
    logic                       rd_slot;
    eeprom_host_pkg::ee_data_t  rd_data;

    // start, ctrl, addr, restart, rd ctrl, then the data byte
    assign rd_slot = is_read && (cnt == 3'd5);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cnt       <= '0;
            nack_q    <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= finish;
            if (clear)
            begin
                cnt    <= '0;
                nack_q <= 1'b0;
            end
            else if (done_valid)
            begin
                cnt <= cnt + 1'b1;
                if (!rd_slot)
                    nack_q <= nack_q | done.nack; // read ack is our own nack
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (done_valid && rd_slot)
            rd_data <= done.data;
    end

    always_comb
    begin
        rsp.rd   = is_read;
        rsp.data = is_read ? rd_data : '0;
        rsp.nack = nack_q;
    end

endmodule

//--- eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     req_valid,
    input  eeprom_host_pkg::ee_req_t req,
    output logic                     rsp_valid,
    output eeprom_host_pkg::ee_rsp_t rsp,
    output logic                     busy,
    output logic                     scl,
    output logic                     sda_oe,  // high pulls sda low
    input  logic                     sda_in
);
    logic                      txn_start;
    logic                      is_read;
    eeprom_bus_pkg::bus_byte_t ctrl_wr_byte;
    eeprom_bus_pkg::bus_byte_t ctrl_rd_byte;
    eeprom_bus_pkg::bus_byte_t addr_byte;
    eeprom_bus_pkg::bus_byte_t data_byte;
    logic                      cmd_valid;
    eeprom_bus_pkg::bus_cmd_t  cmd;
    logic                      done_valid;
    eeprom_bus_pkg::bus_done_t done;
    logic                      clear;
    logic                      finish;

    eeprom_req_decode decode_i
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .req_valid    (req_valid),
        .req          (req),
        .busy         (busy),
        .txn_start    (txn_start),
        .is_read      (is_read),
        .ctrl_wr_byte (ctrl_wr_byte),
        .ctrl_rd_byte (ctrl_rd_byte),
        .addr_byte    (addr_byte),
        .data_byte    (data_byte)
    );

    eeprom_seq_ctrl seq_i
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .txn_start    (txn_start),
        .is_read      (is_read),
        .ctrl_wr_byte (ctrl_wr_byte),
        .ctrl_rd_byte (ctrl_rd_byte),
        .addr_byte    (addr_byte),
        .data_byte    (data_byte),
        .done_valid   (done_valid),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .clear        (clear),
        .finish       (finish),
        .busy         (busy)
    );

    i2c_bit_engine engine_i
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .done_valid (done_valid),
        .done       (done),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

    eeprom_result result_i
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .clear      (clear),
        .is_read    (is_read),
        .done_valid (done_valid),
        .done       (done),
        .finish     (finish),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

//--- eeprom_slave_model.sv
`timescale 1ns/1ps

module eeprom_slave_model
(
    input  logic scl,
    input  logic sda,
    input  logic ack_enable,
    output logic sda_low      // high pulls sda low
);
    typedef enum logic [2:0]
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } slave_mode_e;

    logic [7:0]  mem [0:2047];
    slave_mode_e mode;
    logic [7:0]  shift;
    logic [3:0]  bit_cnt;
    logic        in_ack;
    logic        acked;
    logic [2:0]  blk;
    logic [7:0]  word;

    initial
    begin
        logic [11:0] a;
        for (a = 0; a < 12'd2048; a++)
            mem[a[10:0]] = a[7:0] ^ {5'b0, a[10:8]};
        mode    = M_IDLE;
        sda_low = 1'b0;
        in_ack  = 1'b0;
        acked   = 1'b0;
        bit_cnt = '0;
    end

    // called at the scl fall that ends an ack slot
    task automatic advance_mode();
        if (!acked)
            mode = M_IDLE; // nacked, ignore until next start
        else
        begin
            case (mode)
                M_CTRL:
                begin
                    blk = shift[3:1];
                    if (shift[0])
                    begin
                        mode    = M_RDATA;
                        shift   = mem[{blk, word}];
                        sda_low = !shift[7];
                    end
                    else
                        mode = M_ADDR;
                end
                M_ADDR:
                begin
                    word = shift;
                    mode = M_WDATA;
                end
                M_WDATA:
                begin
                    mem[{blk, word}] = shift;
                    mode             = M_IDLE; // single byte only
                end
                default: mode = M_IDLE;
            endcase
        end
    endtask

    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode    = M_CTRL; // start or repeated start
            bit_cnt = '0;
            in_ack  = 1'b0;
            sda_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode    = M_IDLE; // stop
            sda_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (mode != M_IDLE && !in_ack)
        begin
            if (mode != M_RDATA)
                shift = {shift[6:0], sda};
            bit_cnt = bit_cnt + 1'b1;
        end
    end

    always @(negedge scl)
    begin
        if (in_ack)
        begin
            in_ack  = 1'b0;
            sda_low = 1'b0;
            bit_cnt = '0;
            advance_mode();
        end
        else if (bit_cnt == 4'd8 && mode == M_RDATA)
        begin
            sda_low = 1'b0; // master drives its ack
            in_ack  = 1'b1;
        end
        else if (bit_cnt == 4'd8 && mode != M_IDLE)
        begin
            acked   = ack_enable && (mode != M_CTRL || shift[7:4] == 4'b1010);
            sda_low = acked;
            in_ack  = 1'b1;
        end
        else if (mode == M_RDATA)
            sda_low = !shift[7 - bit_cnt]; // msb first
    end

endmodule

//--- eeprom_checker.sv
`timescale 1ns/1ps

module eeprom_checker
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     req_valid,
    input  eeprom_host_pkg::ee_req_t req,
    input  logic                     busy,
    input  logic                     rsp_valid,
    input  eeprom_host_pkg::ee_rsp_t rsp,
    input  logic                     scl,
    input  logic                     sda_oe,
    input  logic                     ack_enable,
    output int                       error_count,
    output int                       check_count,
    output int                       pending
);
    eeprom_host_pkg::ee_data_t shadow [0:2047];
    eeprom_host_pkg::ee_rsp_t  expect_q [$];
    logic                      accepted_q;
    logic                      reset_q;

    initial
    begin
        logic [11:0] a;
        for (a = 0; a < 12'd2048; a++)
            shadow[a[10:0]] = a[7:0] ^ {5'b0, a[10:8]}; // power-up pattern
        error_count = 0;
        check_count = 0;
        pending     = 0;
    end

    // memory only changes on an acknowledged write
    function automatic eeprom_host_pkg::ee_rsp_t predict(input eeprom_host_pkg::ee_req_t r,
                                                         input logic acked);
        eeprom_host_pkg::ee_rsp_t e;
        e.rd   = r.rd;
        e.nack = !acked;
        e.data = '0;
        if (acked && r.rd)
            e.data = shadow[r.addr];
        else if (acked)
            shadow[r.addr] = r.data;
        return e;
    endfunction

    task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] got);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_response();
        eeprom_host_pkg::ee_rsp_t e;
        if (expect_q.size() == 0)
        begin
            error_count++;
            $display("a response arrived without an accepted request");
        end
        else
        begin
            e       = expect_q.pop_front();
            pending = expect_q.size();
            compare("busy", 8'h00, busy);
            compare("rsp.rd", e.rd, rsp.rd);
            compare("rsp.nack", e.nack, rsp.nack);
            if (!(e.rd && e.nack))
                compare("rsp.data", e.data, rsp.data); // no read data after a nack
        end
    endtask

    always @(posedge CLK)
    begin
        reset_q    <= RESET;
        accepted_q <= !RESET && req_valid && !busy;
        if (!RESET)
        begin
            if (reset_q)
            begin
                compare("busy", 8'h00, busy); // bus released out of reset
                compare("scl", 8'h01, scl);
                compare("sda_oe", 8'h00, sda_oe);
            end
            if (accepted_q)
                compare("busy", 8'h01, busy);
            if (req_valid && !busy)
            begin
                expect_q.push_back(predict(req, ack_enable));
                pending = expect_q.size();
            end
            if (rsp_valid)
                check_response();
        end
    end

endmodule

//--- tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module tb_eeprom_ctrl;
    localparam int SLOT_CYCLES = 4 * `EE_QUARTER;
    localparam int NUM_TXN     = 69; // accepted requests over all tests
    localparam int TXN_LIMIT   = 60 * SLOT_CYCLES;
    localparam int WATCHDOG    = NUM_TXN * TXN_LIMIT + 2000;

    logic                     CLK;
    logic                     RESET;
    logic                     req_valid;
    eeprom_host_pkg::ee_req_t req;
    logic                     rsp_valid;
    eeprom_host_pkg::ee_rsp_t rsp;
    logic                     busy;
    logic                     scl;
    logic                     sda_oe;
    logic                     sda;
    logic                     slave_low;
    logic                     ack_enable;
    int                       error_count;
    int                       check_count;
    int                       pending;
    int                       tb_errors;
    int                       test_base;
    int                       seed;
    string                    test_name;

    assign sda = (sda_oe === 1'b1 || slave_low === 1'b1) ? 1'b0 : 1'b1; // pull-up

    eeprom_ctrl_top dut_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .busy      (busy),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    eeprom_slave_model slave_i
    (
        .scl        (scl),
        .sda        (sda),
        .ack_enable (ack_enable),
        .sda_low    (slave_low)
    );

    eeprom_checker chk_i
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .scl         (scl),
        .sda_oe      (sda_oe),
        .ack_enable  (ack_enable),
        .error_count (error_count),
        .check_count (check_count),
        .pending     (pending)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #5 CLK = ~CLK;
    end

    initial
    begin
        repeat (WATCHDOG) @(posedge CLK);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic begin_test(input string name);
        test_name = name;
        test_base = error_count + tb_errors;
    endtask

    task automatic end_test();
        int errs;
        @(posedge CLK); // checker takes the last response on this edge
        #1;
        if (pending != 0)
        begin
            tb_errors++;
            $display("%0d accepted requests never got a response", pending);
        end
        errs = error_count + tb_errors - test_base;
        if (errs == 0)
            $display("test %s: ok", test_name);
        else
            $display("test %s: %0d errors", test_name, errs);
    endtask

    // one-cycle strobe that returns 1 ns into the next cycle
    task automatic send_request(input logic rd, input eeprom_host_pkg::ee_addr_t addr,
                                input eeprom_host_pkg::ee_data_t data);
        @(posedge CLK);
        #1;
        req_valid = 1'b1;
        req.rd    = rd;
        req.addr  = addr;
        req.data  = data;
        @(posedge CLK);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_response();
        int n;
        n = 0;
        while (!rsp_valid && n < TXN_LIMIT)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (!rsp_valid)
        begin
            tb_errors++;
            $display("no response within %0d cycles of the request", TXN_LIMIT);
        end
    endtask

    task automatic transact(input logic rd, input eeprom_host_pkg::ee_addr_t addr,
                            input eeprom_host_pkg::ee_data_t data);
        send_request(rd, addr, data);
        wait_response();
        if (!rd)
            repeat (10) @(posedge CLK); // write cycle time instead of polling
    endtask

    initial
    begin
        int                        i;
        logic [3:0]                blk;
        eeprom_host_pkg::ee_addr_t a;
        eeprom_host_pkg::ee_data_t d;
        logic                      rd;
        seed       = 57704;
        tb_errors  = 0;
        test_base  = 0;
        RESET      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        ack_enable = 1'b1;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;

        begin_test("reset state");
        repeat (3) @(posedge CLK);
        end_test();

        begin_test("initial pattern");
        for (i = 0; i < 8; i++)
        begin
            a = $random(seed);
            transact(1'b1, a, 8'h00);
        end
        end_test();

        begin_test("write then read, all blocks");
        for (blk = 0; blk < 8; blk++)
        begin
            a       = $random(seed);
            a[10:8] = blk[2:0];
            d       = $random(seed);
            transact(1'b0, a, d);
            transact(1'b1, a, 8'h00);
        end
        end_test();

        begin_test("missing acknowledge");
        ack_enable = 1'b0;
        transact(1'b0, 11'h1a7, 8'h5a);
        transact(1'b1, 11'h1a7, 8'h00);
        ack_enable = 1'b1;
        end_test();

        begin_test("request while busy");
        send_request(1'b0, 11'h2c5, 8'h3c);
        repeat (20) @(posedge CLK);
        send_request(1'b0, 11'h5a3, 8'hc3); // dropped
        send_request(1'b1, 11'h2c5, 8'h00); // dropped
        wait_response();
        repeat (10) @(posedge CLK);
        transact(1'b1, 11'h5a3, 8'h00);
        transact(1'b1, 11'h2c5, 8'h00);
        end_test();

        begin_test("random mix");
        for (i = 0; i < 40; i++)
        begin
            rd = $random(seed);
            a  = $random(seed) & 11'h603; // small pool so reads hit writes
            d  = $random(seed);
            transact(rd, a, d);
        end
        end_test();

        $display("summary: %0d checks, %0d errors", check_count, error_count + tb_errors);
        if (error_count + tb_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- files.f
+incdir+.
eeprom_bus_pkg.sv
eeprom_host_pkg.sv
eeprom_req_decode.sv
eeprom_seq_ctrl.sv
i2c_bit_engine.sv
eeprom_result.sv
eeprom_ctrl_top.sv
eeprom_slave_model.sv
eeprom_checker.sv
tb_eeprom_ctrl.sv

//--- Bender.yml
package:
  name: eeprom_ctrl

sources:
  - include_dirs:
      - .
    files:
      - eeprom_bus_pkg.sv
      - eeprom_host_pkg.sv
      - eeprom_req_decode.sv
      - eeprom_seq_ctrl.sv
      - i2c_bit_engine.sv
      - eeprom_result.sv
      - eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - eeprom_slave_model.sv
      - eeprom_checker.sv
      - tb_eeprom_ctrl.sv
